// File: trace_vectors.txt
# ctrl ic pc instr irqno raddr rwdata daddr dwdata apb paddr pw0 exp prdata pslverr
# ctrl bits: 0 fe 1 ifv 2 pcset 3 c 4 idv 5 dec 6 ill 7 int 8 exv 9 rwe 10 req 11 gnt 12 dwe
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 00 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 00 0 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 3 00000000 1
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 04 0 3 00000000 1
0031 0000 00000100 00a00093 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0301 0000 00000000 00000000 00 01 0000000a 00000000 00000000 0 00 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 00000100 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 08 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 08 0 1 00a00093 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 0c 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 0c 0 2 03000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 10 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 10 0 1 0000000a 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0031 0000 00000104 00112223 00 00 00000000 00000000 00000000 1 00 0 0 00000000 0
1d01 0000 00000000 00000000 00 00 00000000 00001004 0000000a 3 00 0 1 00000000 0
0031 0000 00000108 00412183 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0f01 0000 00000000 00000000 00 03 0000000a 00001004 00000000 0 00 0 0 00000000 0
0003 4505 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0039 4505 0000010c 00004505 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0301 0000 00000000 00000000 00 0a 00000001 00000000 00000000 0 00 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 14 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 14 0 1 00001004 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 18 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 18 0 1 0000000a 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 0c 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 0c 0 2 c0000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 14 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 14 0 1 00001004 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 0c 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 0c 0 2 47000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 10 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 10 0 1 0000000a 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 18 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 18 0 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 08 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 08 0 1 00004505 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 0c 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 0c 0 2 15010000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0085 0000 00000000 00000000 07 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0003 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000040 34202573 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0003 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000044 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0061 0000 00000048 ffffffff 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 0c 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 0c 0 2 003c0000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 0c 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 0c 0 2 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 0c 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 0c 0 2 00020000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 08 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 08 0 1 ffffffff 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0031 0000 00000200 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000204 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000208 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 0000020c 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000210 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000214 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000218 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 0000021c 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000220 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0031 0000 00000224 00000013 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0101 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 00 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 00 0 1 00000208 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 00000200 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 00000204 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 00000208 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 0000020c 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 00000210 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 00000214 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 00000218 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 04 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 04 0 1 0000021c 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 5 1c 1 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 7 1c 1 1 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 1 00 0 0 00000000 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 3 00 0 1 00000200 0
0001 0000 00000000 00000000 00 00 00000000 00000000 00000000 0 00 0 0 00000000 0

// File: vlog.f
+incdir+.
trace_pkg.sv
trace_capture.sv
trace_fifo.sv
trace_apb_port.sv
trace_unit_top.sv
tb_trace_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the trace unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_trace_unit -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_trace_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb_trace_unit.sv
// testbench of the trace unit, plays the core and the debugger from trace_vectors.txt
`timescale 1ns/1ns
`include "trace_settings.svh"

module tb_trace_unit;

  logic                  clk;
  logic                  rst_n;
  trace_pkg::core_tap_t  tap;
  trace_pkg::apb_req_t   apb_req;
  trace_pkg::apb_rsp_t   apb_rsp;

  // one vector line
  logic [15:0] ctrl;
  logic [15:0] ic;
  logic [31:0] pc;
  logic [31:0] ins;
  logic [7:0]  irqn;
  logic [7:0]  ra;
  logic [31:0] rwd;
  logic [31:0] da;
  logic [31:0] dwd;
  logic [3:0]  apbf;
  logic [7:0]  paddr;
  logic [3:0]  pw;
  int          expk;
  logic [31:0] exp_rd;
  logic [3:0]  exp_err;

  int          fd;
  int          n_lines;
  int          err_cnt;
  int          chk_cnt;
  integer      seed;
  logic [15:0] edge_cnt;
  // cycle stamps of the records expected in the buffer, oldest first
  logic [15:0] stamp_q[$];

  trace_unit_top trace_unit_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .tap     (tap),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // next data line of the vector file, comment and blank lines skipped
  task automatic next_vector(output int ok);
    string line;
    int    n;
    ok = 0;
    while (!ok && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 4 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %d %h %h",
                    ctrl, ic, pc, ins, irqn, ra, rwd, da, dwd,
                    apbf, paddr, pw, expk, exp_rd, exp_err);
        ok = (n == 15);
      end
    end
  endtask

  task automatic drive_vector();
    trace_pkg::core_tap_t tv;
    trace_pkg::apb_req_t  av;
    logic [31:0]          rnd;
    tv                  = '0;
    tv.fetch_enable     = ctrl[0];
    tv.if_valid         = ctrl[1];
    tv.pc_set           = ctrl[2];
    tv.is_compressed    = ctrl[3];
    tv.id_valid         = ctrl[4];
    tv.is_decoding      = ctrl[5];
    tv.is_illegal       = ctrl[6];
    tv.is_interrupt     = ctrl[7];
    tv.ex_valid         = ctrl[8];
    tv.ex_reg_we        = ctrl[9];
    tv.ex_data_req      = ctrl[10];
    tv.ex_data_gnt      = ctrl[11];
    tv.ex_data_we       = ctrl[12];
    tv.instr_compressed = ic;
    tv.pc               = pc;
    tv.instr            = ins;
    tv.irq_no           = irqn[4:0];
    tv.ex_reg_addr      = ra[4:0];
    tv.ex_reg_wdata     = rwd;
    tv.ex_data_addr     = da;
    tv.ex_data_wdata    = dwd;
    rnd                 = $random(seed);
    av.psel             = apbf[0];
    av.penable          = apbf[1];
    av.pwrite           = apbf[2];
    av.paddr            = paddr;
    // only bit 0 of pwdata carries meaning
    av.pwdata           = {rnd[31:1], pw[0]};
    tap     <= tv;
    apb_req <= av;
    // issue is seen at the next edge, when the counter equals edge_cnt
    if (ctrl[5] && (ctrl[4] || ctrl[6]) && stamp_q.size() < `TRACE_FIFO_DEPTH) begin
      stamp_q.push_back(edge_cnt);
    end
    if (apbf == 4'h7 && paddr == `TRACE_REG_POP && pw[0] && stamp_q.size() > 0) begin
      void'(stamp_q.pop_front());
    end
  endtask

  // response checks in the access phase
  task automatic check_response();
    logic [31:0] want;
    want = exp_rd;
    if (expk == 2 && stamp_q.size() > 0) begin
      want = exp_rd | {16'h0000, stamp_q[0]};
    end
    if (expk != 3) begin
      chk_cnt++;
      assert (apb_rsp.prdata === want) else begin
        $display("[ERROR] %0t ns prdata expected %h actual %h", $time, want, apb_rsp.prdata);
        err_cnt++;
      end
    end
    chk_cnt++;
    assert (apb_rsp.pslverr === exp_err[0]) else begin
      $display("[ERROR] %0t ns pslverr expected %h actual %h",
               $time, exp_err[0], apb_rsp.pslverr);
      err_cnt++;
    end
    // no wait states, every access phase completes at once
    chk_cnt++;
    assert (apb_rsp.pready === 1'b1) else begin
      $display("[ERROR] %0t ns pready expected 1 actual %h", $time, apb_rsp.pready);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int    ok;
    int    more;
    string line;
    tap      = '0;
    apb_req  = '0;
    rst_n    = 1'b0;
    seed     = 32'h2783;
    err_cnt  = 0;
    chk_cnt  = 0;
    edge_cnt = '0;
    n_lines  = 0;
    fd = $fopen("trace_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      // first pass sizes the watchdog
      while (!$feof(fd)) begin
        line = "";
        ok = $fgets(line, fd);
        if (ok > 4 && line.getc(0) != "#") begin
          n_lines++;
        end
      end
      $fclose(fd);
      fd = $fopen("trace_vectors.txt", "r");
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      more = 1;
      while (more) begin
        @(posedge clk);
        if (rst_n) begin
          edge_cnt++;
        end
        next_vector(ok);
        if (!ok) begin
          more = 0;
        end else begin
          drive_vector();
          if (expk != 0) begin
            @(negedge clk);
            check_response();
          end
        end
      end
      $fclose(fd);
      $display("errors: %0d checks: %0d", err_cnt, chk_cnt);
      if (err_cnt == 0 && chk_cnt > 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

  // watchdog
  initial begin
    wait (n_lines > 0);
    #((n_lines + 20) * 40);
    $display("run timed out before the vectors were done");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: trace_unit_top.sv
// top of the retirement trace unit, core taps in and apb slave port out
`timescale 1ns/1ns

module trace_unit_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  trace_pkg::core_tap_t tap,
  input  trace_pkg::apb_req_t  apb_req,
  output trace_pkg::apb_rsp_t  apb_rsp
);

  ////////////////////////////////////////////////////////////
  // internal links
  ////////////////////////////////////////////////////////////

  // producer -> buffer
  logic                  push;
  logic                  full;
  trace_pkg::trace_rec_t rec;

  // buffer -> consumer
  logic                  pop;
  trace_pkg::trace_rec_t head;
  trace_pkg::fifo_stat_t stat;

  ////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////

  trace_capture trace_capture_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .tap   (tap),
    .full  (full),
    .push  (push),
    .rec   (rec)
  );

  trace_fifo trace_fifo_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (push),
    .rec   (rec),
    .pop   (pop),
    .full  (full),
    .head  (head),
    .stat  (stat)
  );

  // debugger side
  trace_apb_port trace_apb_port_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .head    (head),
    .stat    (stat),
    .pop     (pop)
  );

endmodule

// File: trace_apb_port.sv
// apb slave of the trace unit, shows the head record and buffer status and pops on request
`timescale 1ns/1ns
`include "trace_settings.svh"

module trace_apb_port (
  input  logic                  clk,
  input  logic                  rst_n,
  input  trace_pkg::apb_req_t   apb_req,
  output trace_pkg::apb_rsp_t   apb_rsp,
  input  trace_pkg::trace_rec_t head,
  input  trace_pkg::fifo_stat_t stat,
  output logic                  pop
);

  ////////////////////////////////////////////////////////////
  // phase tracking
  ////////////////////////////////////////////////////////////

  logic        psel_q;
  logic        access;
  logic        empty;
  logic        is_pop_reg;
  logic        is_rec_reg;
  logic        mapped;
  logic [31:0] status_word;
  logic [31:0] info_word;
  logic [31:0] rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      psel_q <= 1'b0;
    end else begin
      psel_q <= apb_req.psel;
    end
  end

  // access phase only counts after a cycle with psel high
  assign access = apb_req.psel & apb_req.penable & psel_q;
  assign empty  = (stat.level == 4'd0);

  ////////////////////////////////////////////////////////////
  // register decode
  ////////////////////////////////////////////////////////////

  assign status_word = {16'h0000, stat.overflow, 4'h0, stat.level};

  assign info_word = {head.mem_we,
                      head.mem_valid,
                      head.reg_addr,
                      head.reg_we,
                      head.irq_no,
                      head.irq,
                      head.illegal,
                      head.compressed,
                      16'(head.cycle)};

  always_comb begin
    rdata      = 32'h0;
    mapped     = 1'b1;
    is_rec_reg = 1'b1;
    is_pop_reg = 1'b0;
    case (apb_req.paddr)
      `TRACE_REG_STATUS: begin
        rdata      = status_word;
        is_rec_reg = 1'b0;
      end
      `TRACE_REG_PC:    rdata = head.pc;
      `TRACE_REG_INSTR: rdata = head.instr;
      `TRACE_REG_INFO:  rdata = info_word;
      `TRACE_REG_RDATA: rdata = head.reg_wdata;
      `TRACE_REG_MADDR: rdata = head.mem_addr;
      `TRACE_REG_MDATA: rdata = head.mem_wdata;
      // pop reads back as zero
      `TRACE_REG_POP: begin
        is_rec_reg = 1'b0;
        is_pop_reg = 1'b1;
      end
      default: begin
        mapped     = 1'b0;
        is_rec_reg = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // response and pop
  ////////////////////////////////////////////////////////////

  assign apb_rsp.prdata = rdata;
  // no wait states
  assign apb_rsp.pready = access;

  // unmapped, write to anything but pop, or record read with nothing buffered
  assign apb_rsp.pslverr = access &
                           (~mapped |
                            (apb_req.pwrite & ~is_pop_reg) |
                            (~apb_req.pwrite & is_rec_reg & empty));

  // takes effect at the edge that closes the access phase
  assign pop = access & apb_req.pwrite & is_pop_reg & apb_req.pwdata[0] & ~empty;

  a_penable_after_psel: assert property (
    @(posedge clk) disable iff (!rst_n) apb_req.penable |-> psel_q
  );

endmodule

// File: trace_fifo.sv
// circular record buffer between trace producer and apb consumer, counts records dropped when full
`timescale 1ns/1ns
`include "trace_settings.svh"

module trace_fifo #(
  parameter int DEPTH = `TRACE_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  trace_pkg::trace_rec_t  rec,
  input  logic                   pop,
  output logic                   full,
  output trace_pkg::trace_rec_t  head,
  output trace_pkg::fifo_stat_t  stat
);

  localparam int PTR_W = $clog2(DEPTH);

  trace_pkg::trace_rec_t mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  // wide enough for DEPTH 16
  logic [4:0]            count;
  logic [7:0]            drop_cnt;
  logic                  wr_en;
  logic                  rd_en;

  // push into a full buffer is dropped even if a pop comes along
  assign full  = (count == 5'(DEPTH));
  assign wr_en = push & ~full;
  assign rd_en = pop & (count != 5'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      drop_cnt <= '0;
    end else begin
      // pointers wrap by themselves since DEPTH is a power of two
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 5'd1;
        2'b01:   count <= count - 5'd1;
        default: count <= count;
      endcase
      // saturate at 255
      if (push && full && (drop_cnt != 8'hFF)) begin
        drop_cnt <= drop_cnt + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= rec;
    end
  end

  assign head = mem[rd_ptr];

  // level field is 4 bits, clamp a full 16 deep buffer
  assign stat.level    = count[4] ? 4'hF : count[3:0];
  assign stat.overflow = drop_cnt;

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> (count != 5'd0)
  );

endmodule

// File: trace_capture.sv
// trace producer: tags interrupts, stamps cycles and builds one record per issued instruction
`timescale 1ns/1ns
`include "trace_settings.svh"

module trace_capture (
  input  logic                  clk,
  input  logic                  rst_n,
  input  trace_pkg::core_tap_t  tap,
  input  logic                  full,
  output logic                  push,
  output trace_pkg::trace_rec_t rec
);

  ////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////

  logic [`TRACE_CYCLE_W-1:0] cycle_q;
  logic                      fetch_seen_q;
  // interrupt tag as it travels IF -> ID
  logic                      irq_if_q;
  logic                      irq_id_q;
  logic [4:0]                irq_no_if_q;
  logic [4:0]                irq_no_id_q;
  // halfword of the compressed instruction sitting in ID
  logic [15:0]               instr_c_id_q;

  // EX slot holding the record until ex_valid
  trace_pkg::trace_rec_t     slot_q;
  trace_pkg::trace_rec_t     slot_next;
  trace_pkg::trace_rec_t     new_rec;
  logic                      slot_busy_q;
  logic                      push_q;
  logic                      issue;

  // valid decode, or an illegal decode that never reaches EX
  assign issue = (fetch_seen_q | tap.fetch_enable) & tap.is_decoding &
                 (tap.id_valid | tap.is_illegal);

  ////////////////////////////////////////////////////////////
  // record build and EX merge
  ////////////////////////////////////////////////////////////

  always_comb begin
    new_rec            = '0;
    new_rec.cycle      = cycle_q;
    new_rec.pc         = tap.pc;
    new_rec.compressed = tap.is_compressed;
    new_rec.illegal    = tap.is_illegal;
    new_rec.irq        = irq_id_q;
    if (tap.is_compressed) begin
      new_rec.instr = {16'h0000, instr_c_id_q};
    end else begin
      new_rec.instr = tap.instr;
    end
    if (irq_id_q) begin
      new_rec.irq_no = irq_no_id_q;
    end
  end

  always_comb begin
    slot_next = slot_q;
    // later writes overwrite earlier ones
    if (tap.ex_reg_we) begin
      slot_next.reg_we    = 1'b1;
      slot_next.reg_addr  = tap.ex_reg_addr;
      slot_next.reg_wdata = tap.ex_reg_wdata;
    end
    // only the first granted access is kept
    if (tap.ex_data_req && tap.ex_data_gnt && !slot_q.mem_valid) begin
      slot_next.mem_valid = 1'b1;
      slot_next.mem_we    = tap.ex_data_we;
      slot_next.mem_addr  = tap.ex_data_addr;
      // loads carry no write data
      slot_next.mem_wdata = tap.ex_data_we ? tap.ex_data_wdata : 32'h0;
    end
  end

  ////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q      <= '0;
      fetch_seen_q <= 1'b0;
      irq_if_q     <= 1'b0;
      irq_id_q     <= 1'b0;
      slot_busy_q  <= 1'b0;
      push_q       <= 1'b0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      if (tap.fetch_enable) begin
        fetch_seen_q <= 1'b1;
      end
      // pc_set wins over if_valid for the IF tag
      if (tap.pc_set) begin
        irq_if_q <= tap.is_interrupt;
      end else if (tap.if_valid) begin
        irq_if_q <= 1'b0;
      end
      if (tap.if_valid) begin
        irq_id_q <= irq_if_q;
      end
      // ex_valid at the issue edge belongs to the older instruction
      if (issue) begin
        slot_busy_q <= 1'b1;
      end else if (slot_busy_q && tap.ex_valid) begin
        slot_busy_q <= 1'b0;
      end
      push_q <= slot_busy_q & tap.ex_valid;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (tap.pc_set) begin
      irq_no_if_q <= tap.irq_no;
    end
    if (tap.if_valid) begin
      irq_no_id_q  <= irq_no_if_q;
      instr_c_id_q <= tap.instr_compressed;
    end
    if (issue) begin
      slot_q <= new_rec;
    end else if (slot_busy_q) begin
      slot_q <= slot_next;
    end
  end

  // slot stays stable during the push cycle
  assign push = push_q;
  assign rec  = slot_q;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_no_issue_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n) issue |-> !slot_busy_q
  );

endmodule

// File: trace_pkg.sv
// shared types of the trace unit (core taps, trace record, apb, buffer status), used by scoped name
`include "trace_settings.svh"

package trace_pkg;

  // everything the tracer samples from the core ID and EX stages
  typedef struct packed {
    logic        fetch_enable;
    logic [15:0] instr_compressed;
    logic        if_valid;
    logic        pc_set;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        is_compressed;
    logic        id_valid;
    logic        is_decoding;
    logic        is_illegal;
    logic        is_interrupt;
    logic [4:0]  irq_no;
    logic        ex_valid;
    logic [4:0]  ex_reg_addr;
    logic        ex_reg_we;
    logic [31:0] ex_reg_wdata;
    logic        ex_data_req;
    logic        ex_data_gnt;
    logic        ex_data_we;
    logic [31:0] ex_data_addr;
    logic [31:0] ex_data_wdata;
  } core_tap_t;

  // one issued instruction
  typedef struct packed {
    logic [`TRACE_CYCLE_W-1:0] cycle;
    logic [31:0]               pc;
    // compressed words sit zero extended in the low half
    logic [31:0]               instr;
    logic                      compressed;
    logic                      illegal;
    logic                      irq;
    logic [4:0]                irq_no;
    // last register write seen in EX
    logic                      reg_we;
    logic [4:0]                reg_addr;
    logic [31:0]               reg_wdata;
    // first granted data access
    logic                      mem_valid;
    logic                      mem_we;
    logic [31:0]               mem_addr;
    logic [31:0]               mem_wdata;
  } trace_rec_t;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [3:0] level;
    logic [7:0] overflow;
  } fifo_stat_t;

endpackage

// File: trace_settings.svh
// buffer depth, cycle stamp width and register map of the trace unit, included by RTL and bench
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// record buffer
////////////////////////////////////////////////////////////

// power of two, 2 to 16
`define TRACE_FIFO_DEPTH 8

// width of the free running cycle stamp
`define TRACE_CYCLE_W 16

////////////////////////////////////////////////////////////
// apb register offsets
////////////////////////////////////////////////////////////

`define TRACE_REG_STATUS 8'h00
`define TRACE_REG_PC     8'h04
`define TRACE_REG_INSTR  8'h08
`define TRACE_REG_INFO   8'h0C
`define TRACE_REG_RDATA  8'h10
`define TRACE_REG_MADDR  8'h14
`define TRACE_REG_MDATA  8'h18
`define TRACE_REG_POP    8'h1C

`endif
